/* hdl/video_pkg.sv */
package video_pkg;

    // grey pixel width
    localparam int pix_w = 8;

    // ----------------------------------------
    // line buffer pool
    // ----------------------------------------
    localparam int num_bufs = 8;
    localparam int buf_bits = 3;

    // pixel address inside one line, 720 fits
    localparam int addr_bits = 10;

    // ----------------------------------------
    // descriptor queue
    // ----------------------------------------
    // one extra bit so the count can reach num_bufs
    localparam int cnt_bits = buf_bits + 1;

endpackage

/* hdl/video_timing.sv */
module video_timing #(
    parameter int h_active = 720,
    parameter int h_fp     = 16,
    parameter int h_sync   = 62,
    parameter int h_bp     = 60,
    parameter int v_active = 480,
    parameter int v_fp     = 9,
    parameter int v_sync   = 6,
    parameter int v_bp     = 30
) (
    input  logic                            pix_clk,
    input  logic                            resetn,
    output logic [video_pkg::addr_bits-1:0] h_pos,
    output logic                            active_pix,
    output logic                            line_start,
    output logic                            frame_start,
    output logic                            de,
    output logic                            hsync,
    output logic                            vsync
);
    import video_pkg::*;

    localparam int h_total = h_active + h_fp + h_sync + h_bp;
    localparam int v_total = v_active + v_fp + v_sync + v_bp;
    localparam int cnt_w   = addr_bits + 1;

    logic [cnt_w-1:0] h_cnt;
    logic [cnt_w-1:0] v_cnt;
    logic [cnt_w-1:0] v_next;
    logic             h_last;
    logic             hs_win;
    logic             vs_win;

    // ----------------------------------------
    // raster counters
    // ----------------------------------------
    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_next;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_last = (h_cnt == h_total - 1);
    // row that follows the current one
    assign v_next = (v_cnt == v_total - 1) ? '0 : v_cnt + 1'b1;

    assign h_pos      = h_cnt[addr_bits-1:0];
    assign active_pix = (h_cnt < h_active) && (v_cnt < v_active);

    // early pulses, one cycle ahead of column 0 of an active row
    assign line_start  = h_last && (v_next < v_active);
    assign frame_start = h_last && (v_cnt == v_total - 1);

    assign hs_win = (h_cnt >= h_active + h_fp) && (h_cnt < h_active + h_fp + h_sync);
    assign vs_win = (v_cnt >= v_active + v_fp) && (v_cnt < v_active + v_fp + v_sync);

    // one stage delay to line up with the store read
    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            de    <= 1'b0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            de    <= active_pix;
            hsync <= !hs_win;
            vsync <= !vs_win;
        end
    end

endmodule

/* hdl/line_capture.sv */
module line_capture #(
    parameter int h_active = 720
) (
    input  logic                            pix_clk,
    input  logic                            resetn,
    input  logic                            cam_line_valid,
    input  logic                            cam_y_valid,
    input  logic                            cam_frame_toggle,
    input  logic [video_pkg::num_bufs-1:0]  release_mask,
    output logic                            wr_en,
    output logic [video_pkg::buf_bits-1:0]  wr_buf,
    output logic [video_pkg::addr_bits-1:0] wr_addr,
    output logic                            desc_push,
    output logic [video_pkg::buf_bits-1:0]  desc_buf,
    output logic                            desc_marker
);
    import video_pkg::*;

    logic [num_bufs-1:0]  free_map;
    logic [num_bufs-1:0]  free_avail;
    logic [num_bufs-1:0]  alloc_mask;
    logic [buf_bits-1:0]  alloc_idx;
    logic                 alloc_ok;
    logic                 line_valid_d;
    logic                 toggle_d;
    logic                 line_rise;
    logic                 line_fall;
    logic                 frame_edge;
    logic                 marker_next;
    logic                 line_marker;
    logic                 line_drop;
    logic [buf_bits-1:0]  line_buf;
    logic [addr_bits-1:0] addr_cnt;
    logic                 write_ok;

    assign line_rise  = cam_line_valid && !line_valid_d;
    assign line_fall  = !cam_line_valid && line_valid_d;
    assign frame_edge = cam_frame_toggle ^ toggle_d;

    // ----------------------------------------
    // lowest free buffer
    // ----------------------------------------
    // released buffers are usable in the same cycle
    assign free_avail = free_map | release_mask;

    always_comb begin
        alloc_ok   = 1'b0;
        alloc_idx  = '0;
        alloc_mask = '0;
        for (int i = num_bufs - 1; i >= 0; i--) begin
            if (free_avail[i]) begin
                alloc_ok  = 1'b1;
                alloc_idx = buf_bits'(i);
            end
        end
        if (line_rise && alloc_ok) begin
            alloc_mask[alloc_idx] = 1'b1;
        end
    end

    // ----------------------------------------
    // write port
    // ----------------------------------------
    // first cycle of a line writes straight to the new buffer at 0
    assign wr_buf   = line_rise ? alloc_idx : line_buf;
    assign wr_addr  = line_rise ? '0 : addr_cnt;
    assign write_ok = line_rise ? alloc_ok : !line_drop;
    assign wr_en    = cam_line_valid && cam_y_valid && write_ok && (wr_addr < h_active);

    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            free_map     <= '1;
            line_valid_d <= 1'b0;
            toggle_d     <= 1'b0;
            marker_next  <= 1'b0;
            line_marker  <= 1'b0;
            line_drop    <= 1'b0;
            line_buf     <= '0;
            addr_cnt     <= '0;
            desc_push    <= 1'b0;
            desc_buf     <= '0;
            desc_marker  <= 1'b0;
        end else begin
            line_valid_d <= cam_line_valid;
            toggle_d     <= cam_frame_toggle;
            free_map     <= free_avail & ~alloc_mask;

            if (wr_en) begin
                addr_cnt <= wr_addr + 1'b1;
            end else if (line_rise) begin
                addr_cnt <= '0;
            end

            if (frame_edge) begin
                marker_next <= 1'b1;
            end

            if (line_rise) begin
                line_buf    <= alloc_idx;
                line_drop   <= !alloc_ok;
                line_marker <= marker_next || frame_edge;
                marker_next <= 1'b0;
            end

            // push one cycle after the line ends
            desc_push <= line_fall && !line_drop;
            if (line_fall) begin
                desc_buf    <= line_buf;
                desc_marker <= line_marker;
                // a dropped field start hands its marker on
                if (line_drop && line_marker) begin
                    marker_next <= 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/line_store.sv */
module line_store (
    input  logic                            pix_clk,
    input  logic                            resetn,
    input  logic                            wr_en,
    input  logic [video_pkg::buf_bits-1:0]  wr_buf,
    input  logic [video_pkg::addr_bits-1:0] wr_addr,
    input  logic [video_pkg::pix_w-1:0]     cam_y,
    input  logic [video_pkg::addr_bits-1:0] h_pos,
    input  logic                            active_pix,
    input  logic [video_pkg::buf_bits-1:0]  cur_buf,
    input  logic                            cur_valid,
    output logic [video_pkg::pix_w-1:0]     pix_y
);
    import video_pkg::*;

    localparam int depth = num_bufs * (2 ** addr_bits);

    // all line buffers in one array, indexed by {buffer, column}
    logic [pix_w-1:0] mem [depth];

    logic [buf_bits+addr_bits-1:0] wr_index;
    logic [buf_bits+addr_bits-1:0] rd_index;
    logic                          rd_en;

    assign wr_index = {wr_buf, wr_addr};
    assign rd_index = {cur_buf, h_pos};
    assign rd_en    = active_pix && cur_valid;

    // ----------------------------------------
    // camera write port
    // ----------------------------------------
    always_ff @(posedge pix_clk) begin
        if (wr_en) begin
            mem[wr_index] <= cam_y;
        end
    end

    // ----------------------------------------
    // display read port
    // ----------------------------------------
    // blanking and no current line both read as black
    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            pix_y <= '0;
        end else if (rd_en) begin
            pix_y <= mem[rd_index];
        end else begin
            pix_y <= '0;
        end
    end

endmodule

/* hdl/line_scheduler.sv */
module line_scheduler (
    input  logic                           pix_clk,
    input  logic                           resetn,
    input  logic                           desc_push,
    input  logic [video_pkg::buf_bits-1:0] desc_buf,
    input  logic                           desc_marker,
    input  logic                           line_start,
    input  logic                           frame_start,
    output logic [video_pkg::num_bufs-1:0] release_mask,
    output logic [video_pkg::buf_bits-1:0] cur_buf,
    output logic                           cur_valid
);
    import video_pkg::*;

    // ----------------------------------------
    // descriptor storage
    // ----------------------------------------
    logic [buf_bits-1:0] q_buf [num_bufs];
    logic [num_bufs-1:0] q_marker;

    logic [buf_bits-1:0] wr_ptr;
    logic [buf_bits-1:0] rd_ptr;
    logic [cnt_bits-1:0] count;

    logic                phase;
    logic                phase_eff;
    logic                head_marker;
    logic                pop;

    // depth matches the buffer count so a push always finds room
    always_ff @(posedge pix_clk) begin
        if (desc_push) begin
            q_buf[wr_ptr]    <= desc_buf;
            q_marker[wr_ptr] <= desc_marker;
        end
    end

    // ----------------------------------------
    // bob repeat
    // ----------------------------------------
    // new frame always begins with a fresh pair
    assign phase_eff   = phase && !frame_start;
    assign head_marker = q_marker[rd_ptr];

    // phase 0 takes the next line, a field start may cut a pair short
    assign pop = line_start && (count != '0) && (!phase_eff || head_marker);

    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            phase        <= 1'b0;
            cur_buf      <= '0;
            cur_valid    <= 1'b0;
            release_mask <= '0;
        end else begin
            release_mask <= '0;

            if (desc_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + cnt_bits'(desc_push) - cnt_bits'(pop);

            // after any pop the phase is 0, then it toggles to 1
            if (line_start) begin
                phase <= pop ? 1'b1 : !phase_eff;
            end

            if (pop) begin
                cur_buf   <= q_buf[rd_ptr];
                cur_valid <= 1'b1;
                // old line goes back to the free map
                if (cur_valid) begin
                    release_mask[cur_buf] <= 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/cam_video_top.sv */
module cam_video_top #(
    parameter int h_active = 720,
    parameter int h_fp     = 16,
    parameter int h_sync   = 62,
    parameter int h_bp     = 60,
    parameter int v_active = 480,
    parameter int v_fp     = 9,
    parameter int v_sync   = 6,
    parameter int v_bp     = 30
) (
    input  logic                        pix_clk,
    input  logic                        resetn,
    input  logic                        cam_line_valid,
    input  logic                        cam_y_valid,
    input  logic                        cam_frame_toggle,
    input  logic [video_pkg::pix_w-1:0] cam_y,
    output logic                        de,
    output logic                        hsync,
    output logic                        vsync,
    output logic [video_pkg::pix_w-1:0] pix_y
);
    import video_pkg::*;

    // raster
    logic [addr_bits-1:0] h_pos;
    logic                 active_pix;
    logic                 line_start;
    logic                 frame_start;

    // capture side
    logic                 wr_en;
    logic [buf_bits-1:0]  wr_buf;
    logic [addr_bits-1:0] wr_addr;
    logic                 desc_push;
    logic [buf_bits-1:0]  desc_buf;
    logic                 desc_marker;

    // display side
    logic [num_bufs-1:0]  release_mask;
    logic [buf_bits-1:0]  cur_buf;
    logic                 cur_valid;

    // ----------------------------------------
    // output raster
    // ----------------------------------------
    video_timing #(
        .h_active (h_active),
        .h_fp     (h_fp),
        .h_sync   (h_sync),
        .h_bp     (h_bp),
        .v_active (v_active),
        .v_fp     (v_fp),
        .v_sync   (v_sync),
        .v_bp     (v_bp)
    ) video_timing_i (
        .pix_clk     (pix_clk),
        .resetn      (resetn),
        .h_pos       (h_pos),
        .active_pix  (active_pix),
        .line_start  (line_start),
        .frame_start (frame_start),
        .de          (de),
        .hsync       (hsync),
        .vsync       (vsync)
    );

    // ----------------------------------------
    // camera lines into the pool
    // ----------------------------------------
    line_capture #(
        .h_active (h_active)
    ) line_capture_i (
        .pix_clk          (pix_clk),
        .resetn           (resetn),
        .cam_line_valid   (cam_line_valid),
        .cam_y_valid      (cam_y_valid),
        .cam_frame_toggle (cam_frame_toggle),
        .release_mask     (release_mask),
        .wr_en            (wr_en),
        .wr_buf           (wr_buf),
        .wr_addr          (wr_addr),
        .desc_push        (desc_push),
        .desc_buf         (desc_buf),
        .desc_marker      (desc_marker)
    );

    line_store line_store_i (
        .pix_clk    (pix_clk),
        .resetn     (resetn),
        .wr_en      (wr_en),
        .wr_buf     (wr_buf),
        .wr_addr    (wr_addr),
        .cam_y      (cam_y),
        .h_pos      (h_pos),
        .active_pix (active_pix),
        .cur_buf    (cur_buf),
        .cur_valid  (cur_valid),
        .pix_y      (pix_y)
    );

    line_scheduler line_scheduler_i (
        .pix_clk      (pix_clk),
        .resetn       (resetn),
        .desc_push    (desc_push),
        .desc_buf     (desc_buf),
        .desc_marker  (desc_marker),
        .line_start   (line_start),
        .frame_start  (frame_start),
        .release_mask (release_mask),
        .cur_buf      (cur_buf),
        .cur_valid    (cur_valid)
    );

endmodule

/* sim/tb_cam_video.sv */
module tb_cam_video;
    timeunit 1ns;
    timeprecision 1ps;
    import video_pkg::*;

    // small raster of 24 x 12 cycles per frame
    localparam int h_active   = 16;
    localparam int h_fp       = 2;
    localparam int h_sync     = 3;
    localparam int h_bp       = 3;
    localparam int v_active   = 8;
    localparam int v_fp       = 1;
    localparam int v_sync     = 1;
    localparam int v_bp       = 2;
    localparam int h_total    = h_active + h_fp + h_sync + h_bp;
    localparam int max_cycles = 12000;

    logic             pix_clk;
    logic             resetn;
    logic             cam_line_valid;
    logic             cam_y_valid;
    logic             cam_frame_toggle;
    logic [pix_w-1:0] cam_y;
    logic             de;
    logic             hsync;
    logic             vsync;
    logic [pix_w-1:0] pix_y;

    int seed         = 32'h6f39_4deb;
    int cycles       = 0;
    int raster_errs  = 0;
    int content_errs = 0;

    // lines handed to the camera in send order
    logic [pix_w-1:0] sent_base [256];
    logic             sent_marker [256];
    logic             sent_may_drop [256];
    int               sent_cnt = 0;

    // raster measurement
    int   de_run;
    int   hs_run;
    int   vs_run;
    int   hs_per;
    int   de_lines;
    logic hs_seen;
    logic de_q;
    logic hs_q;
    logic vs_q;

    // line monitor state
    int               mon_col;
    int               last_idx;
    int               shown;
    int               out_row;
    int               pair_shown;
    logic             seen_real;
    logic             blank_line;
    logic             chk_pix;
    logic             pair_due;
    logic             skip_due;
    logic             skip_legal;
    logic             no_match;
    logic [pix_w-1:0] cur_base;
    logic [pix_w-1:0] exp_y;

    cam_video_top #(
        .h_active (h_active),
        .h_fp     (h_fp),
        .h_sync   (h_sync),
        .h_bp     (h_bp),
        .v_active (v_active),
        .v_fp     (v_fp),
        .v_sync   (v_sync),
        .v_bp     (v_bp)
    ) cam_video_top_i (
        .pix_clk          (pix_clk),
        .resetn           (resetn),
        .cam_line_valid   (cam_line_valid),
        .cam_y_valid      (cam_y_valid),
        .cam_frame_toggle (cam_frame_toggle),
        .cam_y            (cam_y),
        .de               (de),
        .hsync            (hsync),
        .vsync            (vsync),
        .pix_y            (pix_y)
    );

    initial begin
        pix_clk = 1'b0;
        forever #20 pix_clk = !pix_clk;
    end

    always @(posedge pix_clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, last sent line never reached the display", cycles);
            $display("raster errors %0d, content errors %0d", raster_errs, content_errs);
            $display("** FAIL **");
            $finish;
        end
    end

    // ----------------------------------------
    // camera model
    // ----------------------------------------
    task automatic send_line(input int n, input logic mark, input logic may_drop, input int idle);
        int sent;
        sent = 0;
        if (mark) begin
            @(posedge pix_clk);
            cam_frame_toggle <= !cam_frame_toggle;
            repeat (2) @(posedge pix_clk);
        end
        sent_base[sent_cnt]     = pix_w'(n * 16);
        sent_marker[sent_cnt]   = mark;
        sent_may_drop[sent_cnt] = may_drop;
        sent_cnt++;
        while (sent < h_active) begin
            @(posedge pix_clk);
            cam_line_valid <= 1'b1;
            cam_y          <= pix_w'(n * 16 + sent);
            if (($random(seed) & 3) != 0) begin
                cam_y_valid <= 1'b1;
                sent++;
            end else begin
                cam_y_valid <= 1'b0;
            end
        end
        @(posedge pix_clk);
        cam_line_valid <= 1'b0;
        cam_y_valid    <= 1'b0;
        repeat (idle) @(posedge pix_clk);
    endtask

    initial begin : stimulus
        int n;
        resetn           = 1'b0;
        cam_line_valid   = 1'b0;
        cam_y_valid      = 1'b0;
        cam_frame_toggle = 1'b0;
        cam_y            = '0;
        repeat (8) @(posedge pix_clk);
        resetn <= 1'b1;
        repeat (30) @(posedge pix_clk);
        // slower than the display
        for (n = 1; n <= 18; n++) begin
            send_line(n, n == 5 || n == 12, 1'b0, 100 + ($random(seed) & 63));
        end
        // burst that outruns the display and fills the pool
        for (n = 19; n <= 32; n++) begin
            send_line(n, n == 24, 1'b1, 2 + ($random(seed) & 3));
        end
        // slow again while the first few may still meet a full pool
        for (n = 33; n <= 50; n++) begin
            send_line(n, n == 40 || n == 41, n < 36, 100 + ($random(seed) & 63));
        end
        while (!(seen_real && last_idx == sent_cnt - 1 && shown >= 2)) begin
            @(posedge pix_clk);
        end
        repeat (2 * h_total * 12) @(posedge pix_clk);
        $display("raster errors %0d, content errors %0d", raster_errs, content_errs);
        if (raster_errs + content_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // ----------------------------------------
    // raster measurement
    // ----------------------------------------
    always @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            de_q     <= 1'b0;
            hs_q     <= 1'b1;
            vs_q     <= 1'b1;
            de_run   <= 0;
            hs_run   <= 0;
            vs_run   <= 0;
            hs_per   <= 0;
            hs_seen  <= 1'b0;
            de_lines <= 0;
        end else begin
            de_q   <= de;
            hs_q   <= hsync;
            vs_q   <= vsync;
            de_run <= de ? de_run + 1 : 0;
            hs_run <= !hsync ? hs_run + 1 : 0;
            vs_run <= !vsync ? vs_run + 1 : 0;
            if (!hsync && hs_q) begin
                hs_per  <= 1;
                hs_seen <= 1'b1;
            end else begin
                hs_per <= hs_per + 1;
            end
            if (!vsync && vs_q) begin
                de_lines <= 0;
            end else if (de && !de_q) begin
                de_lines <= de_lines + 1;
            end
        end
    end

    // ----------------------------------------
    // output line monitor
    // ----------------------------------------
    // column 0 names the line and later columns follow from its base
    assign exp_y = blank_line ? '0 : cur_base + pix_w'(mon_col);

    always @(posedge pix_clk or negedge resetn) begin : line_monitor
        int   found;
        int   from;
        logic cut;
        logic legal;
        if (!resetn) begin
            mon_col    <= 0;
            last_idx   <= 0;
            shown      <= 0;
            out_row    <= 0;
            pair_shown <= 0;
            seen_real  <= 1'b0;
            blank_line <= 1'b1;
            chk_pix    <= 1'b0;
            pair_due   <= 1'b0;
            skip_due   <= 1'b0;
            skip_legal <= 1'b1;
            no_match   <= 1'b0;
            cur_base   <= '0;
        end else begin
            pair_due <= 1'b0;
            skip_due <= 1'b0;
            no_match <= 1'b0;
            if (!vsync) begin
                out_row <= 0;
            end else if (!de && de_q) begin
                out_row <= out_row + 1;
            end
            if (!de) begin
                mon_col <= 0;
            end else begin
                mon_col <= mon_col + 1;
                if (mon_col == 0) begin
                    found = -1;
                    from  = seen_real ? last_idx + 1 : 0;
                    if (seen_real && pix_y == sent_base[last_idx]) begin
                        shown      <= shown + 1;
                        blank_line <= 1'b0;
                        chk_pix    <= 1'b1;
                    end else if (!seen_real && pix_y == '0) begin
                        blank_line <= 1'b1;
                        chk_pix    <= 1'b1;
                    end else begin
                        for (int k = from; k < sent_cnt; k++) begin
                            if (found < 0 && sent_base[k] == pix_y) begin
                                found = k;
                            end
                        end
                        if (found < 0) begin
                            no_match <= 1'b1;
                            chk_pix  <= 1'b0;
                        end else begin
                            cut   = 1'b0;
                            legal = 1'b1;
                            // markers of dropped lines pass to the next kept line
                            for (int k = from; k <= found; k++) begin
                                cut = cut | sent_marker[k];
                            end
                            for (int k = from; k < found; k++) begin
                                legal = legal & sent_may_drop[k];
                            end
                            pair_due   <= seen_real && !cut && out_row != 0;
                            pair_shown <= shown;
                            skip_due   <= 1'b1;
                            skip_legal <= legal;
                            last_idx   <= found;
                            shown      <= 1;
                            seen_real  <= 1'b1;
                            cur_base   <= sent_base[found];
                            blank_line <= 1'b0;
                            chk_pix    <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    reset_out_chk: assert property (@(posedge pix_clk)
        !resetn && cycles != 0 |-> (!de && hsync && vsync && pix_y == '0))
        else begin
            raster_errs++;
            $display("error reset de/hsync/vsync/pix_y: expected 0 1 1 0, actual %b %b %b %0d",
                $sampled(de), $sampled(hsync), $sampled(vsync), $sampled(pix_y));
        end

    de_width_chk: assert property (@(posedge pix_clk) disable iff (!resetn)
        $fell(de) |-> de_run == h_active)
        else begin
            raster_errs++;
            $display("error de width: expected %0d, actual %0d", h_active, $sampled(de_run));
        end

    hs_width_chk: assert property (@(posedge pix_clk) disable iff (!resetn)
        $rose(hsync) |-> hs_run == h_sync)
        else begin
            raster_errs++;
            $display("error hsync width: expected %0d, actual %0d", h_sync, $sampled(hs_run));
        end

    hs_period_chk: assert property (@(posedge pix_clk) disable iff (!resetn)
        $fell(hsync) && hs_seen |-> hs_per == h_total)
        else begin
            raster_errs++;
            $display("error hsync period: expected %0d, actual %0d", h_total, $sampled(hs_per));
        end

    vs_width_chk: assert property (@(posedge pix_clk) disable iff (!resetn)
        $rose(vsync) |-> vs_run == v_sync * h_total)
        else begin
            raster_errs++;
            $display("error vsync width: expected %0d, actual %0d",
                v_sync * h_total, $sampled(vs_run));
        end

    frame_lines_chk: assert property (@(posedge pix_clk) disable iff (!resetn)
        $fell(vsync) |-> de_lines == v_active)
        else begin
            raster_errs++;
            $display("error active lines: expected %0d, actual %0d", v_active, $sampled(de_lines));
        end

    blank_chk: assert property (@(posedge pix_clk) disable iff (!resetn)
        !de |-> pix_y == '0)
        else begin
            content_errs++;
            $display("error blanking pixel: expected 0, actual %0d", $sampled(pix_y));
        end

    pixel_chk: assert property (@(posedge pix_clk) disable iff (!resetn)
        de && chk_pix && mon_col != 0 |-> pix_y == exp_y)
        else begin
            content_errs++;
            $display("error pixel: expected %0d, actual %0d", $sampled(exp_y), $sampled(pix_y));
        end

    order_chk: assert property (@(posedge pix_clk) disable iff (!resetn)
        !no_match)
        else begin
            content_errs++;
            $display("displayed line is not a later sent line, repeated out of order or unknown");
        end

    pair_len_chk: assert property (@(posedge pix_clk) disable iff (!resetn)
        pair_due |-> pair_shown >= 2)
        else begin
            content_errs++;
            $display("error line pairing: expected 2, actual %0d", $sampled(pair_shown));
        end

    skip_chk: assert property (@(posedge pix_clk) disable iff (!resetn)
        skip_due |-> skip_legal)
        else begin
            content_errs++;
            $display("a line was skipped while the camera was not outrunning the display");
        end

endmodule

/* compile.f */
hdl/video_pkg.sv
hdl/video_timing.sv
hdl/line_capture.sv
hdl/line_store.sv
hdl/line_scheduler.sv
hdl/cam_video_top.sv
sim/tb_cam_video.sv

/* Bender.yml */
package:
  name: cam_video

sources:
  # rtl in compile order
  - files:
      - hdl/video_pkg.sv
      - hdl/video_timing.sv
      - hdl/line_capture.sv
      - hdl/line_store.sv
      - hdl/line_scheduler.sv
      - hdl/cam_video_top.sv

  # testbench
  - target: simulation
    files:
      - sim/tb_cam_video.sv
